// ==== project.f ====
+incdir+design
design/p_rv_isa.sv
design/p_id_stage.sv
design/feid_if.sv
design/aligner.sv
design/decoder.sv
design/idop_reg.sv
design/id_stage.sv
design/id_top.sv
test/tb_id_top.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - include_dirs:
      - design
    files:
      - design/p_rv_isa.sv
      - design/p_id_stage.sv
      - design/feid_if.sv
      - design/aligner.sv
      - design/decoder.sv
      - design/idop_reg.sv
      - design/id_stage.sv
      - design/id_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_id_top.sv

// ==== test/id_vectors.txt ====
// instr info pred stall flush scrub_en rep flag | stall_o payload f rd rs1 rs2 sctrl ictrl imiscon
// Inputs held for rep cycles, outputs checked after the last one when flag is 1
402081B3 01 0 00 0 0 01 1 0 000402 8 03 01 02 30 40 0
FFF30293 01 0 00 0 0 01 1 0 1FFFFF 0 05 06 02 22 40 0
00712423 01 0 00 0 0 01 1 0 000008 2 08 02 07 30 10 0
FE400CE3 01 1 00 0 0 01 1 0 1FFFF8 0 19 02 04 38 08 0
12345537 01 0 00 0 0 01 1 0 012345 5 0A 02 04 02 02 0
100000EF 01 0 00 0 0 01 1 0 000100 0 01 02 04 01 04 0
30002173 01 0 00 0 0 01 1 0 000300 2 02 02 04 00 01 0
402081B3 01 0 08 0 0 01 1 1 000300 2 02 02 04 00 01 0
402081B3 01 0 00 0 0 01 1 0 000402 8 03 01 02 30 40 0
00000000 00 0 00 0 0 01 1 0 000402 8 03 01 02 30 00 0
FFF30293 01 0 04 0 0 01 1 0 1FFFFF 0 05 06 02 22 40 0
00712423 01 0 10 1 0 01 1 1 1FFFFF 0 05 06 02 22 00 0
// Straddling SW, then ADDI, then a flush drops the pending half
24230000 03 0 00 0 0 01 1 0 1FFFFF 0 05 06 02 22 00 0
02930071 01 0 00 0 0 01 1 0 000008 2 08 02 07 30 10 0
0000FFF3 01 0 00 0 0 01 1 0 1FFFFF 0 05 06 07 22 40 0
002081B3 01 0 00 1 0 01 1 0 1FFFFF 0 05 06 07 22 00 0
402081B3 01 0 00 0 0 01 1 0 000402 8 03 01 02 30 40 0
00000001 05 1 00 0 0 01 1 0 000000 0 00 01 02 00 00 3
00004501 01 1 00 0 0 01 1 0 000000 4 0A 01 02 00 00 2
0000007F 01 1 00 0 0 01 1 0 000000 0 00 01 02 00 00 1
402081B3 01 1 00 0 0 01 1 0 000402 8 03 01 02 30 40 4
// Read-port scrubbing, including the wrap from 31 to 1
12345537 01 0 00 0 1 01 1 0 012345 5 0A 01 01 02 02 0
12345537 01 0 00 0 1 01 1 0 012345 5 0A 02 02 02 02 0
FFF30293 01 0 00 0 1 01 1 0 1FFFFF 0 05 06 03 22 40 0
402081B3 01 0 00 0 1 01 1 0 000402 8 03 01 02 30 40 0
00000000 00 0 00 0 1 01 1 0 000402 8 03 04 04 30 00 0
12345537 01 0 00 0 1 1A 1 0 012345 5 0A 1E 1E 02 02 0
12345537 01 0 00 0 1 01 1 0 012345 5 0A 1F 1F 02 02 0
12345537 01 0 00 0 1 01 1 0 012345 5 0A 01 01 02 02 0
FFF30293 01 0 00 0 0 01 1 0 1FFFFF 0 05 06 01 22 40 0

// ==== test/tb_id_top.sv ====
/*
   Testbench for the ID stage top level
   Clock and reset, vector file playback, typed compare tasks, cycle timeout
*/
`timescale 1ns/10ps
`include "id_macros.svh"

module tb_id_top;

    localparam int    NF           = 17;    // Tokens per vector line
    localparam int    MAX_VEC      = 64;
    localparam int    RESET_CYCLES = 8;
    localparam int    SLACK        = 20;
    localparam time   SETTLE       = 1;
    localparam string VEC_FILE     = "test/id_vectors.txt";

    logic                  clk;
    logic                  arst_n;
    logic [31:0]           fe_instr;
    logic [4:0]            fe_info;
    logic                  fe_pred;
    logic [4:0]            stall;
    logic                  flush;
    logic                  scrub_en;
    logic                  stall_o;
    logic [`PAYLOAD_W-1:0] idop_payload;
    p_rv_isa::f_part       idop_f;
    p_rv_isa::rf_add       idop_rd;
    p_rv_isa::rf_add       idop_rs1;
    p_rv_isa::rf_add       idop_rs2;
    p_id_stage::sctrl      idop_sctrl;
    p_id_stage::ictrl      idop_ictrl;
    p_id_stage::imiscon    idop_imiscon;

    logic [31:0] vec_mem [0:NF*MAX_VEC-1];
    int          n_vec;
    int          cycles      = 0;
    int          cycle_limit = RESET_CYCLES + SLACK;

    id_top i_dut (
        .s_clk_i          (clk),
        .arst_n_i         (arst_n),
        .fe_instr_i       (fe_instr),
        .fe_info_i        (fe_info),
        .fe_pred_i        (fe_pred),
        .stall_i          (stall),
        .flush_i          (flush),
        .scrub_en_i       (scrub_en),
        .stall_o          (stall_o),
        .s_idop_payload_o (idop_payload),
        .s_idop_f_o       (idop_f),
        .s_idop_rd_o      (idop_rd),
        .s_idop_rs1_o     (idop_rs1),
        .s_idop_rs2_o     (idop_rs2),
        .s_idop_sctrl_o   (idop_sctrl),
        .s_idop_ictrl_o   (idop_ictrl),
        .s_idop_imiscon_o (idop_imiscon)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at %0d ns", $time);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("FAILED at %0d ns: %s expected %0h, got %0h", $time, name, exp, got);
        abort_run();
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            report_mismatch(name, 32'(exp), 32'(got));
        end
    endtask

    task automatic check_rf_add(input string name, input p_rv_isa::rf_add exp,
                                input p_rv_isa::rf_add got);
        if (got !== exp) begin
            report_mismatch(name, 32'(exp), 32'(got));
        end
    endtask

    task automatic check_payload(input logic [`PAYLOAD_W-1:0] exp,
                                 input logic [`PAYLOAD_W-1:0] got);
        if (got !== exp) begin
            report_mismatch("idop_payload", 32'(exp), 32'(got));
        end
    endtask

    task automatic check_f(input p_rv_isa::f_part exp, input p_rv_isa::f_part got);
        if (got !== exp) begin
            report_mismatch("idop_f", 32'(exp), 32'(got));
        end
    endtask

    task automatic check_sctrl(input p_id_stage::sctrl exp, input p_id_stage::sctrl got);
        if (got !== exp) begin
            report_mismatch("idop_sctrl", 32'(exp), 32'(got));
        end
    endtask

    task automatic check_ictrl(input p_id_stage::ictrl exp, input p_id_stage::ictrl got);
        if (got !== exp) begin
            report_mismatch("idop_ictrl", 32'(exp), 32'(got));
        end
    endtask

    task automatic check_imiscon(input p_id_stage::imiscon exp,
                                 input p_id_stage::imiscon got);
        if (got !== exp) begin
            report_mismatch("idop_imiscon", 32'(exp), 32'(got));
        end
    endtask

    // Vector count and run length both come from the file
    task automatic load_vectors();
        int fd;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Vector file %s could not be opened", VEC_FILE);
            abort_run();
        end else begin
            $fclose(fd);
            $readmemh(VEC_FILE, vec_mem);
            n_vec = 0;
            while (n_vec < MAX_VEC && !$isunknown(vec_mem[n_vec*NF])) begin
                cycle_limit += vec_mem[n_vec*NF+6];  // Repeat count
                n_vec++;
            end
            if (n_vec == 0) begin
                $display("Vector file %s holds no vectors", VEC_FILE);
                abort_run();
            end
        end
    endtask

    // Applies one line for rep cycles and checks it after the last one
    task automatic run_vector(input int v);
        int   base;
        int   rep;
        int   r;
        logic check;
        base  = v * NF;
        rep   = vec_mem[base+6];
        check = vec_mem[base+7][0];
        for (r = 0; r < rep; r++) begin
            @(negedge clk);
            fe_instr = vec_mem[base];
            fe_info  = vec_mem[base+1][4:0];
            fe_pred  = vec_mem[base+2][0];
            stall    = vec_mem[base+3][4:0];
            flush    = vec_mem[base+4][0];
            scrub_en = vec_mem[base+5][0];
            #SETTLE;
            if (check && r == rep - 1) begin
                check_bit("stall_o", vec_mem[base+8][0], stall_o);   // Same-cycle stall
            end
            @(posedge clk);
            #SETTLE;
        end
        if (check) begin
            check_payload(vec_mem[base+9][`PAYLOAD_W-1:0], idop_payload);
            check_f(p_rv_isa::f_part'(vec_mem[base+10][3:0]), idop_f);
            check_rf_add("idop_rd", p_rv_isa::rf_add'(vec_mem[base+11][4:0]), idop_rd);
            check_rf_add("idop_rs1", p_rv_isa::rf_add'(vec_mem[base+12][4:0]), idop_rs1);
            check_rf_add("idop_rs2", p_rv_isa::rf_add'(vec_mem[base+13][4:0]), idop_rs2);
            check_sctrl(p_id_stage::sctrl'(vec_mem[base+14][5:0]), idop_sctrl);
            check_ictrl(p_id_stage::ictrl'(vec_mem[base+15][6:0]), idop_ictrl);
            check_imiscon(p_id_stage::imiscon'(vec_mem[base+16][2:0]), idop_imiscon);
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, vectors did not complete", cycles);
            abort_run();
        end
    end

    initial begin
        int v;
        arst_n   = 1'b0;
        fe_instr = '0;
        fe_info  = '0;     // No valid word during reset
        fe_pred  = 1'b0;
        stall    = '0;
        flush    = 1'b0;
        scrub_en = 1'b0;
        load_vectors();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (v = 0; v < n_vec; v++) begin
            run_vector(v);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== design/id_top.sv ====
/*
   ID stage top level
   Plain fetch ports onto the fetch bundle, decode stage with ID/OP outputs
*/
`timescale 1ns/10ps
`include "id_macros.svh"

module id_top (
    input  logic                  s_clk_i,
    input  logic                  arst_n_i,
    input  logic [31:0]           fe_instr_i,
    input  logic [4:0]            fe_info_i,
    input  logic                  fe_pred_i,
    input  logic [4:0]            stall_i,
    input  logic                  flush_i,
    input  logic                  scrub_en_i,
    output logic                  stall_o,     // Fetch holds its word
    output logic [`PAYLOAD_W-1:0] s_idop_payload_o,
    output p_rv_isa::f_part       s_idop_f_o,
    output p_rv_isa::rf_add       s_idop_rd_o,
    output p_rv_isa::rf_add       s_idop_rs1_o,
    output p_rv_isa::rf_add       s_idop_rs2_o,
    output p_id_stage::sctrl      s_idop_sctrl_o,
    output p_id_stage::ictrl      s_idop_ictrl_o,
    output p_id_stage::imiscon    s_idop_imiscon_o
);

    feid_if u_feid ();

    assign u_feid.instr = fe_instr_i;
    assign u_feid.info  = fe_info_i;
    assign u_feid.pred  = fe_pred_i;

    id_stage m_id_stage (
        .s_clk_i          (s_clk_i),
        .arst_n_i         (arst_n_i),
        .fe_i             (u_feid.aligner),
        .s_stall_i        (stall_i),
        .s_flush_i        (flush_i),
        .s_scrub_en_i     (scrub_en_i),
        .s_stall_o        (stall_o),
        .s_idop_payload_o (s_idop_payload_o),
        .s_idop_f_o       (s_idop_f_o),
        .s_idop_rd_o      (s_idop_rd_o),
        .s_idop_rs1_o     (s_idop_rs1_o),
        .s_idop_rs2_o     (s_idop_rs2_o),
        .s_idop_sctrl_o   (s_idop_sctrl_o),
        .s_idop_ictrl_o   (s_idop_ictrl_o),
        .s_idop_imiscon_o (s_idop_imiscon_o)
    );

endmodule

// ==== design/id_stage.sv ====
/*
   Instruction decode stage
   Aligner, decoder, ID/OP registers, stall and flush control, read-port scrubbing
*/
`timescale 1ns/10ps
`include "id_macros.svh"

module id_stage (
    input  logic                  s_clk_i,
    input  logic                  arst_n_i,
    feid_if.aligner               fe_i,
    input  logic [4:0]            s_stall_i,
    input  logic                  s_flush_i,
    input  logic                  s_scrub_en_i,
    output logic                  s_stall_o,
    output logic [`PAYLOAD_W-1:0] s_idop_payload_o,
    output p_rv_isa::f_part       s_idop_f_o,
    output p_rv_isa::rf_add       s_idop_rd_o,
    output p_rv_isa::rf_add       s_idop_rs1_o,
    output p_rv_isa::rf_add       s_idop_rs2_o,
    output p_id_stage::sctrl      s_idop_sctrl_o,
    output p_id_stage::ictrl      s_idop_ictrl_o,
    output p_id_stage::imiscon    s_idop_imiscon_o
);

    logic                   s_stall_id, s_empty, s_nop, s_pred, s_aerr, s_scrub_upd;
    logic                   s_we_aux, s_we_esn, s_we_rs1, s_we_rs2;
    logic [31:0]            s_instr;
    logic [1:0]             s_free_rp;      // Decoded instruction leaves the port unused
    logic [`PAYLOAD_W-1:0]  s_payload;
    p_id_stage::fetch_err_e s_ferr;
    p_rv_isa::f_part        s_f;
    p_rv_isa::rf_add        s_rd, s_rs1, s_rs2, s_wrs1, s_wrs2, s_scrub_add;
    p_id_stage::sctrl       s_sctrl;
    p_id_stage::ictrl       s_ictrl, s_wictrl;
    p_id_stage::imiscon     s_imiscon, s_wimiscon;

    // An empty slot never holds the stage
    assign s_empty    = (s_idop_ictrl_o == '0) && (s_idop_imiscon_o == p_id_stage::IMISCON_FREE);
    assign s_stall_id = (|s_stall_i[p_id_stage::PIPE_MA:p_id_stage::PIPE_OP]) & ~s_empty;

    aligner m_aligner (
        .s_clk_i   (s_clk_i),
        .arst_n_i  (arst_n_i),
        .fe_i      (fe_i),
        .s_stall_i (s_stall_id),
        .s_flush_i (s_flush_i),
        .s_stall_o (s_stall_o),
        .s_nop_o   (s_nop),
        .s_instr_o (s_instr),
        .s_pred_o  (s_pred),
        .s_aerr_o  (s_aerr),
        .s_ferr_o  (s_ferr)
    );

    decoder m_decoder (
        .s_fetch_error_i (s_ferr),
        .s_align_error_i (s_aerr),
        .s_instr_i       (s_instr),
        .s_prediction_i  (s_pred),
        .s_rs1_o         (s_rs1),
        .s_rs2_o         (s_rs2),
        .s_rd_o          (s_rd),
        .s_payload_o     (s_payload),
        .s_f_o           (s_f),
        .s_sctrl_o       (s_sctrl),
        .s_ictrl_o       (s_ictrl),
        .s_imiscon_o     (s_imiscon)
    );

    assign s_we_aux = ~(s_flush_i | s_stall_id | s_nop);
    assign s_we_esn = s_flush_i | ~s_stall_id;     // Flush wins over stall

    // Empty slot on flush or when the aligner has nothing
    assign s_wictrl   = (s_flush_i | s_nop) ? '0 : s_ictrl;
    assign s_wimiscon = (s_flush_i | s_nop) ? p_id_stage::IMISCON_FREE : s_imiscon;

    assign s_free_rp[0] = s_sctrl.zero1 | ~s_sctrl.rfrp1;
    assign s_free_rp[1] = s_sctrl.zero2 | ~s_sctrl.rfrp2;

    // With scrubbing, an unneeded port takes the scrub address instead of holding
    assign s_we_rs1 = s_scrub_en_i ? ~(s_flush_i | s_stall_id) : s_we_aux & ~s_free_rp[0];
    assign s_we_rs2 = s_scrub_en_i ? ~(s_flush_i | s_stall_id) : s_we_aux & ~s_free_rp[1];
    assign s_wrs1   = (s_we_aux & ~s_free_rp[0]) ? s_rs1 : s_scrub_add;
    assign s_wrs2   = (s_we_aux & ~s_free_rp[1]) ? s_rs2 : s_scrub_add;

    assign s_scrub_upd = s_scrub_en_i &
                         (s_flush_i | (~s_stall_id & ((s_free_rp != 2'b00) | s_nop)));

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s_scrub_add <= `SCRUB_FIRST;
        end else if (s_scrub_upd) begin
            s_scrub_add <= (s_scrub_add == `SCRUB_LAST) ? `SCRUB_FIRST : s_scrub_add + 5'd1;
        end
    end

    idop_reg #(.T(logic [`PAYLOAD_W-1:0])) m_idop_payload (.s_clk_i(s_clk_i),
        .arst_n_i(arst_n_i), .s_we_i(s_we_aux), .s_d_i(s_payload), .s_q_o(s_idop_payload_o));
    idop_reg #(.T(p_rv_isa::f_part)) m_idop_f (.s_clk_i(s_clk_i),
        .arst_n_i(arst_n_i), .s_we_i(s_we_aux), .s_d_i(s_f), .s_q_o(s_idop_f_o));
    idop_reg #(.T(p_rv_isa::rf_add)) m_idop_rd (.s_clk_i(s_clk_i),
        .arst_n_i(arst_n_i), .s_we_i(s_we_aux), .s_d_i(s_rd), .s_q_o(s_idop_rd_o));
    idop_reg #(.T(p_rv_isa::rf_add)) m_idop_rs1 (.s_clk_i(s_clk_i),
        .arst_n_i(arst_n_i), .s_we_i(s_we_rs1), .s_d_i(s_wrs1), .s_q_o(s_idop_rs1_o));
    idop_reg #(.T(p_rv_isa::rf_add)) m_idop_rs2 (.s_clk_i(s_clk_i),
        .arst_n_i(arst_n_i), .s_we_i(s_we_rs2), .s_d_i(s_wrs2), .s_q_o(s_idop_rs2_o));
    idop_reg #(.T(p_id_stage::sctrl)) m_idop_sctrl (.s_clk_i(s_clk_i),
        .arst_n_i(arst_n_i), .s_we_i(s_we_aux), .s_d_i(s_sctrl), .s_q_o(s_idop_sctrl_o));
    idop_reg #(.T(p_id_stage::ictrl), .RST(1'b1)) m_idop_ictrl (.s_clk_i(s_clk_i),
        .arst_n_i(arst_n_i), .s_we_i(s_we_esn), .s_d_i(s_wictrl), .s_q_o(s_idop_ictrl_o));
    idop_reg #(.T(p_id_stage::imiscon), .RST(1'b1)) m_idop_imiscon (.s_clk_i(s_clk_i),
        .arst_n_i(arst_n_i), .s_we_i(s_we_esn), .s_d_i(s_wimiscon), .s_q_o(s_idop_imiscon_o));

endmodule

// ==== design/idop_reg.sv ====
/*
   ID/OP pipeline register
   Any payload type, write enable, reset to zero when RST is set
*/
`timescale 1ns/10ps

module idop_reg #(
    parameter type T   = logic,
    parameter bit  RST = 1'b0
) (
    input  logic s_clk_i,
    input  logic arst_n_i,
    input  logic s_we_i,
    input  T     s_d_i,
    output T     s_q_o
);

    if (RST) begin : g_rst
        always_ff @(posedge s_clk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
                s_q_o <= T'(0);
            end else if (s_we_i) begin
                s_q_o <= s_d_i;
            end
        end
    end else begin : g_plain
        always_ff @(posedge s_clk_i) begin
            if (s_we_i) begin
                s_q_o <= s_d_i;
            end
        end
    end

endmodule

// ==== design/decoder.sv ====
/*
   RV32I decoder
   Register addresses, immediate payload, function, control fields and misconduct
*/
`timescale 1ns/10ps
`include "id_macros.svh"

module decoder (
    input  p_id_stage::fetch_err_e s_fetch_error_i,
    input  logic                   s_align_error_i,
    input  logic [31:0]            s_instr_i,
    input  logic                   s_prediction_i,
    output p_rv_isa::rf_add        s_rs1_o,
    output p_rv_isa::rf_add        s_rs2_o,
    output p_rv_isa::rf_add        s_rd_o,
    output logic [`PAYLOAD_W-1:0]  s_payload_o,
    output p_rv_isa::f_part        s_f_o,
    output p_id_stage::sctrl       s_sctrl_o,
    output p_id_stage::ictrl       s_ictrl_o,
    output p_id_stage::imiscon     s_imiscon_o
);

    logic [`PAYLOAD_W-1:0] s_imm_i;
    logic [`PAYLOAD_W-1:0] s_imm_s;
    logic [`PAYLOAD_W-1:0] s_imm_b;
    logic [`PAYLOAD_W-1:0] s_imm_j;
    logic [`PAYLOAD_W-1:0] s_imm_u;
    logic                  s_alt;       // funct7 bit 5 is part of the function
    logic                  s_illegal;

    assign s_rd_o  = s_instr_i[11:7];
    assign s_rs1_o = s_instr_i[19:15];
    assign s_rs2_o = s_instr_i[24:20];
    assign s_f_o   = {s_alt & s_instr_i[30], s_instr_i[14:12]};

    // Sign-extended immediates, cut to the payload width
    assign s_imm_i = {{(`PAYLOAD_W-12){s_instr_i[31]}}, s_instr_i[31:20]};
    assign s_imm_s = {{(`PAYLOAD_W-12){s_instr_i[31]}}, s_instr_i[31:25], s_instr_i[11:7]};
    assign s_imm_b = {{(`PAYLOAD_W-13){s_instr_i[31]}}, s_instr_i[31], s_instr_i[7],
                      s_instr_i[30:25], s_instr_i[11:8], 1'b0};
    assign s_imm_j = {s_instr_i[31], s_instr_i[19:12], s_instr_i[20], s_instr_i[30:21], 1'b0};
    assign s_imm_u = {1'b0, s_instr_i[31:12]};  // Upper 20 bits, shifted in OP stage

    always_comb begin : decode
        s_sctrl_o   = '0;
        s_ictrl_o   = '0;
        s_payload_o = s_imm_i;
        s_alt       = 1'b0;
        s_illegal   = 1'b0;
        case (s_instr_i[6:0])
            p_rv_isa::OPC_LUI: begin
                s_ictrl_o.upper = 1'b1;
                s_sctrl_o.imm   = 1'b1;
                s_payload_o     = s_imm_u;
            end
            p_rv_isa::OPC_AUIPC: begin
                s_ictrl_o.upper = 1'b1;
                s_sctrl_o.imm   = 1'b1;
                s_sctrl_o.pc    = 1'b1;
                s_payload_o     = s_imm_u;
            end
            p_rv_isa::OPC_JAL: begin
                s_ictrl_o.jump = 1'b1;
                s_sctrl_o.pc   = 1'b1;
                s_payload_o    = s_imm_j;
            end
            p_rv_isa::OPC_JALR: begin
                s_ictrl_o.jump  = 1'b1;
                s_sctrl_o.rfrp1 = 1'b1;
            end
            p_rv_isa::OPC_BRANCH: begin
                s_ictrl_o.branch = 1'b1;
                s_sctrl_o.rfrp1  = 1'b1;
                s_sctrl_o.rfrp2  = 1'b1;
                s_payload_o      = s_imm_b;
            end
            p_rv_isa::OPC_LOAD: begin
                s_ictrl_o.load  = 1'b1;
                s_sctrl_o.rfrp1 = 1'b1;
            end
            p_rv_isa::OPC_STORE: begin
                s_ictrl_o.store = 1'b1;
                s_sctrl_o.rfrp1 = 1'b1;
                s_sctrl_o.rfrp2 = 1'b1;
                s_payload_o     = s_imm_s;
            end
            p_rv_isa::OPC_OP_IMM: begin
                s_ictrl_o.alu   = 1'b1;
                s_sctrl_o.rfrp1 = 1'b1;
                s_sctrl_o.imm   = 1'b1;
                s_alt           = (s_instr_i[14:12] == 3'b101);  // SRAI versus SRLI
            end
            p_rv_isa::OPC_OP: begin
                s_ictrl_o.alu   = 1'b1;
                s_sctrl_o.rfrp1 = 1'b1;
                s_sctrl_o.rfrp2 = 1'b1;
                s_alt           = 1'b1;
            end
            p_rv_isa::OPC_MISC_MEM, p_rv_isa::OPC_SYSTEM: begin
                s_ictrl_o.sys = 1'b1;   // CSR address travels in the payload
            end
            default: s_illegal = 1'b1;
        endcase
        s_sctrl_o.zero1 = s_sctrl_o.rfrp1 & (s_rs1_o == '0);
        s_sctrl_o.zero2 = s_sctrl_o.rfrp2 & (s_rs2_o == '0);
    end

    // Highest priority first
    always_comb begin : misconduct
        if (s_fetch_error_i != p_id_stage::FETCH_OK) begin
            s_imiscon_o = p_id_stage::IMISCON_FETCH_ERR;
        end else if (s_align_error_i) begin
            s_imiscon_o = p_id_stage::IMISCON_MISALIGN;
        end else if (s_illegal) begin
            s_imiscon_o = p_id_stage::IMISCON_ILLEGAL;
        end else if (s_prediction_i && !(s_ictrl_o.branch || s_ictrl_o.jump)) begin
            s_imiscon_o = p_id_stage::IMISCON_MISPRED_HINT;
        end else begin
            s_imiscon_o = p_id_stage::IMISCON_FREE;
        end
    end

endmodule

// ==== design/aligner.sv ====
/*
   Instruction aligner
   Rebuilds instructions that straddle two fetch words, flags alignment and fetch errors
*/
`timescale 1ns/10ps

module aligner (
    input  logic                   s_clk_i,
    input  logic                   arst_n_i,
    feid_if.aligner                fe_i,
    input  logic                   s_stall_i,
    input  logic                   s_flush_i,
    output logic                   s_stall_o,
    output logic                   s_nop_o,
    output logic [31:0]            s_instr_o,
    output logic                   s_pred_o,
    output logic                   s_aerr_o,
    output p_id_stage::fetch_err_e s_ferr_o
);

    logic        s_valid;
    logic        s_upper;
    logic        s_half_vld;    // Upper halfword of previous word pending
    logic [15:0] s_half;

    assign s_valid = fe_i.info[0];
    assign s_upper = fe_i.info[1];

    // Low half comes from the stored halfword when one is pending
    assign s_instr_o = s_half_vld ? {fe_i.instr[15:0], s_half} : fe_i.instr;
    assign s_nop_o   = ~s_valid | (~s_half_vld & s_upper);
    assign s_aerr_o  = (s_instr_o[1:0] != 2'b11);   // Compressed encodings not supported
    assign s_ferr_o  = p_id_stage::fetch_err_e'(fe_i.info[4:2]);
    assign s_pred_o  = fe_i.pred;
    assign s_stall_o = s_stall_i;

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s_half_vld <= 1'b0;
        end else if (s_flush_i) begin
            s_half_vld <= 1'b0;
        end else if (!s_stall_i) begin
            // A straddling start keeps the chain going word after word
            s_half_vld <= s_valid & (s_half_vld | s_upper);
        end
    end

    // Upper halfword is kept whenever a word is consumed
    always_ff @(posedge s_clk_i) begin
        if (!s_stall_i && s_valid) begin
            s_half <= fe_i.instr[31:16];
        end
    end

endmodule

// ==== design/feid_if.sv ====
/*
   Fetch to ID bundle
   Fetch word, info field and prediction bit
*/
`timescale 1ns/10ps

interface feid_if;

    logic [31:0] instr;     // Fetch word, 4-byte aligned
    logic [4:0]  info;      // Valid, upper-half start, fetch error
    logic        pred;      // Branch predicted taken

    modport fetch (output instr, info, pred);
    modport aligner (input instr, info, pred);

endinterface

// ==== design/p_id_stage.sv ====
/*
   Pipeline-stage types
   Source and instruction control, misconduct codes, fetch errors, stall indices
*/
package p_id_stage;

    // Operand sources for the OP stage
    typedef struct packed {
        logic rfrp1;    // Read port 1 needed
        logic rfrp2;    // Read port 2 needed
        logic zero1;    // rs1 is x0
        logic zero2;    // rs2 is x0
        logic imm;      // Payload used as operand
        logic pc;       // PC used as operand
    } sctrl;

    // One-hot instruction class, all zero marks an empty slot
    typedef struct packed {
        logic alu;
        logic load;
        logic store;
        logic branch;
        logic jump;
        logic upper;
        logic sys;
    } ictrl;

    typedef enum logic [2:0] {
        IMISCON_FREE         = 3'd0,
        IMISCON_ILLEGAL      = 3'd1,
        IMISCON_MISALIGN     = 3'd2,
        IMISCON_FETCH_ERR    = 3'd3,
        IMISCON_MISPRED_HINT = 3'd4
    } imiscon;

    // Error field of the fetch info
    typedef enum logic [2:0] {
        FETCH_OK     = 3'd0,
        FETCH_BUSERR = 3'd1,
        FETCH_INCER  = 3'd2
    } fetch_err_e;

    // Positions in the 5-bit stall vector
    localparam int PIPE_OP = 2;
    localparam int PIPE_EX = 3;
    localparam int PIPE_MA = 4;

endpackage

// ==== design/p_rv_isa.sv ====
/*
   RV32I encoding types
   Register address, function code and major opcodes
*/
`include "id_macros.svh"

package p_rv_isa;

    // Register-file address
    typedef logic [`RF_ADD_W-1:0] rf_add;

    // funct7 bit 5 on top of funct3
    typedef logic [3:0] f_part;

    // Major opcodes of the base set
    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

endpackage

// ==== design/id_macros.svh ====
/*
   Width definitions for the ID stage
   Scrub address range of the register-file read ports
*/
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// Register-file address width
`define RF_ADD_W 5

// Immediate payload carried to the OP stage
`define PAYLOAD_W 21

// Scrub range, register x0 is never scrubbed
`define SCRUB_FIRST 5'd1
`define SCRUB_LAST 5'd31

`endif
